// File: hdl/ex_agu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_agu import ex_pkg::*; (
  input  logic            issue,
  input  ex_class_t       cls,
  input  mem_size_t       size,
  input  logic [XLEN-1:0] base,
  input  logic [XLEN-1:0] offset,
  input  logic [XLEN-1:0] store_data,
  ex_mem_req_if.source    req
);

  logic [XLEN-1:0]   addr;
  logic [STRB_W-1:0] strb_base;

  assign addr = base + offset;

  always_comb begin
    case (size)
      SIZE_BYTE: begin
        strb_base = 4'b0001;
        req.wdata = {4{store_data[7:0]}};   // byte in every lane
      end
      SIZE_HALF: begin
        strb_base = 4'b0011;
        req.wdata = {2{store_data[15:0]}};
      end
      default: begin
        strb_base = 4'b1111;
        req.wdata = store_data;
      end
    endcase
  end

  assign req.addr  = addr;
  assign req.wstrb = strb_base << addr[1:0];  // misaligned words are not trapped here
  assign req.valid = issue & ((cls == CLS_LOAD) | (cls == CLS_STORE));
  assign req.we    = (cls == CLS_STORE);

endmodule

`default_nettype wire

// File: hdl/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu import ex_pkg::*; (
  input  alu_op_t         alu_op,
  input  logic [XLEN-1:0] src1,
  input  logic [XLEN-1:0] src2,
  output logic [XLEN-1:0] result,
  output logic            less,
  output logic            zero
);

  localparam int SH_W = $clog2(XLEN);

  logic            do_sub;
  logic [XLEN-1:0] adder_b;
  logic [XLEN-1:0] adder_sum;
  logic            adder_cout;
  logic            slt_bit;
  logic            sltu_bit;
  logic [XLEN-1:0] sll_res;
  logic [2*XLEN-1:0] sr_wide;
  logic [XLEN-1:0] sr_res;

  // sub and both compares run the adder as src1 - src2
  assign do_sub  = alu_op[ALU_SUB] | alu_op[ALU_SLT] | alu_op[ALU_SLTU];
  assign adder_b = do_sub ? ~src2 : src2;
  assign {adder_cout, adder_sum} = {1'b0, src1} + {1'b0, adder_b} + {{XLEN{1'b0}}, do_sub};

  // negative vs positive decides directly, otherwise the difference sign
  assign slt_bit = (src1[XLEN-1] & ~src2[XLEN-1])
                 | ((src1[XLEN-1] ~^ src2[XLEN-1]) & adder_sum[XLEN-1]);
  assign sltu_bit = ~adder_cout;  // borrow out

  assign sll_res = src1 << src2[SH_W-1:0];

  // upper half filled with the sign only for sra
  assign sr_wide = {{XLEN{alu_op[ALU_SRA] & src1[XLEN-1]}}, src1} >> src2[SH_W-1:0];
  assign sr_res  = sr_wide[XLEN-1:0];

  always_comb begin
    result = ({XLEN{alu_op[ALU_ADD] | alu_op[ALU_SUB]}} & adder_sum)
           | ({XLEN{alu_op[ALU_SLT]}}  & {{(XLEN-1){1'b0}}, slt_bit})
           | ({XLEN{alu_op[ALU_SLTU]}} & {{(XLEN-1){1'b0}}, sltu_bit})
           | ({XLEN{alu_op[ALU_AND]}}  & (src1 & src2))
           | ({XLEN{alu_op[ALU_NOR]}}  & ~(src1 | src2))
           | ({XLEN{alu_op[ALU_OR]}}   & (src1 | src2))
           | ({XLEN{alu_op[ALU_XOR]}}  & (src1 ^ src2))
           | ({XLEN{alu_op[ALU_SLL]}}  & sll_res)
           | ({XLEN{alu_op[ALU_SRL] | alu_op[ALU_SRA]}} & sr_res)
           | ({XLEN{alu_op[ALU_LUI]}}  & src2);  // immediate already placed high
  end

  // flags for the branch unit
  assign less = result[0];
  assign zero = ~(|result);

endmodule

`default_nettype wire

// File: hdl/ex_branch.sv
`timescale 1ns/1ps
`default_nettype none

module ex_branch import ex_pkg::*; (
  input  ex_class_t       cls,
  input  br_cond_t        cond,
  input  logic            less,
  input  logic            zero,
  input  logic            use_rj,
  input  logic [XLEN-1:0] pc,
  input  logic [XLEN-1:0] rj_value,
  input  logic [XLEN-1:0] imm,
  input  logic            pre_taken,
  output logic            taken,
  output logic            redirect,
  output logic [XLEN-1:0] redirect_pc,
  output logic [XLEN-1:0] link
);

  logic            cond_ok;
  logic            is_br;
  logic [XLEN-1:0] target;

  always_comb begin
    case (cond)
      BR_EQ:            cond_ok = zero;
      BR_NE:            cond_ok = ~zero;
      BR_LT, BR_LTU:    cond_ok = less;   // alu ran slt or sltu
      BR_GE, BR_GEU:    cond_ok = ~less;
      default:          cond_ok = 1'b1;
    endcase
  end

  assign is_br  = (cls == CLS_BRANCH) | (cls == CLS_JUMP);
  assign taken  = ((cls == CLS_BRANCH) & cond_ok) | (cls == CLS_JUMP);
  assign target = (use_rj ? rj_value : pc) + {imm[XLEN-3:0], 2'b00};  // word offset
  assign link   = pc + 32'd4;

  assign redirect    = is_br & (taken ^ pre_taken);
  assign redirect_pc = taken ? target : link;  // fall through on a wrong taken guess

endmodule

`default_nettype wire

// File: hdl/ex_commit.sv
`timescale 1ns/1ps
`default_nettype none

module ex_commit import ex_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              issue_fire,
  input  ex_class_t         cls,
  input  logic [4:0]        rd,
  input  logic [XLEN-1:0]   alu_result,
  input  logic [XLEN-1:0]   link,
  input  logic              redirect,
  input  logic [XLEN-1:0]   redirect_pc_in,
  ex_mem_req_if.sink        mem_in,
  input  logic              mul_done,
  input  logic [XLEN-1:0]   mul_result,
  input  logic              div_busy,
  input  logic              div_done,
  input  logic [XLEN-1:0]   div_result,
  output logic              issue_ready,
  output logic              wb_valid,
  output logic [4:0]        wb_rd,
  output logic [XLEN-1:0]   wb_data,
  output logic              mem_valid,
  output logic              mem_we,
  output logic [XLEN-1:0]   mem_addr,
  output logic [STRB_W-1:0] mem_wstrb,
  output logic [XLEN-1:0]   mem_wdata,
  output logic              redirect_valid,
  output logic [XLEN-1:0]   redirect_pc
);

  logic            sc_valid_q;
  logic [XLEN-1:0] sc_data_q;
  logic [4:0]      sc_rd_q;
  logic [4:0]      md_rd_q;     // rd of the outstanding mul or div
  logic            mul_hold_q;
  logic            md_done;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sc_valid_q     <= 1'b0;
      mem_valid      <= 1'b0;
      redirect_valid <= 1'b0;
      mul_hold_q     <= 1'b0;
    end else begin
      sc_valid_q     <= issue_fire & ((cls == CLS_ALU) | (cls == CLS_JUMP));
      mem_valid      <= mem_in.valid;  // already qualified by issue
      redirect_valid <= issue_fire & redirect;
      mul_hold_q     <= issue_fire & (cls == CLS_MUL);
    end
  end

  always_ff @(posedge clk) begin
    sc_data_q   <= (cls == CLS_JUMP) ? link : alu_result;
    sc_rd_q     <= rd;
    mem_we      <= mem_in.we;
    mem_addr    <= mem_in.addr;
    mem_wstrb   <= mem_in.wstrb;
    mem_wdata   <= mem_in.wdata;
    redirect_pc <= redirect_pc_in;
    if (issue_fire & ((cls == CLS_MUL) | (cls == CLS_DIV))) begin
      md_rd_q <= rd;
    end
  end

  // ready gaps keep mul/div results off single-cycle slots
  assign md_done  = mul_done | div_done;
  assign wb_valid = sc_valid_q | md_done;
  assign wb_rd    = md_done ? md_rd_q : sc_rd_q;
  assign wb_data  = mul_done ? mul_result : (div_done ? div_result : sc_data_q);

  assign issue_ready = ~mul_hold_q & ~div_busy;

endmodule

`default_nettype wire

// File: hdl/ex_div.sv
`timescale 1ns/1ps
`default_nettype none

module ex_div import ex_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            start,
  input  logic            is_unsigned,
  input  logic            use_mod,
  input  logic [XLEN-1:0] dividend,
  input  logic [XLEN-1:0] divisor,
  output logic            busy,
  output logic            done,
  output logic [XLEN-1:0] result
);

  localparam int CNT_W = $clog2(DIV_STEPS);

  logic             busy_q;
  logic             done_q;
  logic [CNT_W-1:0] cnt_q;
  logic             last_step;

  logic [XLEN-1:0]  dvnd_abs;
  logic [XLEN-1:0]  dvsr_abs;
  logic [XLEN-1:0]  rem_q;
  logic [XLEN-1:0]  quo_q;    // dividend bits shift out as quotient bits shift in
  logic [XLEN-1:0]  dvsr_q;
  logic             neg_q_q;
  logic             neg_r_q;
  logic             mod_q;
  logic [XLEN+1:0]  trial;
  logic [XLEN-1:0]  quo_fix;
  logic [XLEN-1:0]  rem_fix;

  assign dvnd_abs = (~is_unsigned & dividend[XLEN-1]) ? -dividend : dividend;
  assign dvsr_abs = (~is_unsigned & divisor[XLEN-1])  ? -divisor  : divisor;

  // extra top bit keeps the compare exact
  assign trial = {1'b0, rem_q, quo_q[XLEN-1]} - {2'b00, dvsr_q};

  assign last_step = busy_q & (cnt_q == CNT_W'(DIV_STEPS - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= last_step;
      if (start) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (busy_q) begin
        busy_q <= ~last_step;
        cnt_q  <= cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      rem_q   <= '0;
      quo_q   <= dvnd_abs;
      dvsr_q  <= dvsr_abs;
      mod_q   <= use_mod;
      // zero divisor leaves the all ones quotient unsigned
      neg_q_q <= ~is_unsigned & (dividend[XLEN-1] ^ divisor[XLEN-1]) & (|divisor);
      neg_r_q <= ~is_unsigned & dividend[XLEN-1];
    end else if (busy_q) begin
      rem_q <= trial[XLEN+1] ? {rem_q[XLEN-2:0], quo_q[XLEN-1]} : trial[XLEN-1:0];
      quo_q <= {quo_q[XLEN-2:0], ~trial[XLEN+1]};
    end
  end

  // most negative / -1 lands on the most negative value with remainder 0
  assign quo_fix = neg_q_q ? -quo_q : quo_q;
  assign rem_fix = neg_r_q ? -rem_q : rem_q;  // x / 0 gives back the dividend

  assign busy   = busy_q;
  assign done   = done_q;
  assign result = mod_q ? rem_fix : quo_fix;

endmodule

`default_nettype wire

// File: hdl/ex_mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ex_mem_req_if import ex_pkg::*; ();

  logic              valid;  // one cycle per load or store
  logic              we;     // store when high
  logic [XLEN-1:0]   addr;
  logic [STRB_W-1:0] wstrb;
  logic [XLEN-1:0]   wdata;  // already lane replicated

  modport source (output valid, we, addr, wstrb, wdata);
  modport sink   (input  valid, we, addr, wstrb, wdata);

endinterface

`default_nettype wire

// File: hdl/ex_mul.sv
`timescale 1ns/1ps
`default_nettype none

module ex_mul import ex_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            start,
  input  logic            is_unsigned,
  input  logic            use_high,
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  output logic            done,
  output logic [XLEN-1:0] result
);

  logic signed [XLEN:0]     a_q;   // 33 bits, extended by signedness
  logic signed [XLEN:0]     b_q;
  logic                     high_q;
  logic                     vld1_q;
  logic                     vld2_q;
  logic signed [2*XLEN+1:0] prod;
  logic [XLEN-1:0]          result_q;

  // one signed multiplier covers both signed and unsigned
  assign prod = a_q * b_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld1_q <= 1'b0;
      vld2_q <= 1'b0;
    end else begin
      vld1_q <= start;
      vld2_q <= vld1_q;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      a_q    <= {~is_unsigned & a[XLEN-1], a};
      b_q    <= {~is_unsigned & b[XLEN-1], b};
      high_q <= use_high;
    end
    if (vld1_q) begin
      result_q <= high_q ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];  // stage two
    end
  end

  assign done   = vld2_q;
  assign result = result_q;

endmodule

`default_nettype wire

// File: hdl/ex_pkg.sv
`default_nettype none

package ex_pkg;

  localparam int XLEN      = 32;
  localparam int MUL_LAT   = 2;   // issue to wb_valid, in cycles
  localparam int DIV_STEPS = 32;  // one quotient bit per step
  localparam int STRB_W    = XLEN / 8;

  // bit positions inside the one-hot alu_op_t
  localparam int ALU_ADD  = 0;
  localparam int ALU_SUB  = 1;
  localparam int ALU_SLT  = 2;
  localparam int ALU_SLTU = 3;
  localparam int ALU_AND  = 4;
  localparam int ALU_NOR  = 5;
  localparam int ALU_OR   = 6;
  localparam int ALU_XOR  = 7;
  localparam int ALU_SLL  = 8;
  localparam int ALU_SRL  = 9;
  localparam int ALU_SRA  = 10;
  localparam int ALU_LUI  = 11;

  typedef logic [11:0] alu_op_t;

  typedef enum logic [2:0] {
    CLS_ALU,
    CLS_MUL,
    CLS_DIV,
    CLS_LOAD,
    CLS_STORE,
    CLS_BRANCH,
    CLS_JUMP
  } ex_class_t;

  typedef enum logic [1:0] {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD
  } mem_size_t;

  // eq/ne look at zero, the rest of the compares at less
  typedef enum logic [2:0] {
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU,
    BR_ALWAYS
  } br_cond_t;

endpackage

`default_nettype wire

// File: hdl/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage import ex_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              issue_valid,
  output logic              issue_ready,
  input  ex_class_t         cls,
  input  alu_op_t           alu_op,
  input  logic              md_unsigned,
  input  logic              md_high_mod,  // mulh or mod
  input  mem_size_t         mem_size,
  input  br_cond_t          br_cond,
  input  logic              use_rj,
  input  logic [XLEN-1:0]   src1,
  input  logic [XLEN-1:0]   src2,
  input  logic [XLEN-1:0]   imm,
  input  logic [XLEN-1:0]   store_data,
  input  logic [XLEN-1:0]   pc,
  input  logic [4:0]        rd,
  input  logic              pre_taken,
  output logic              wb_valid,
  output logic [4:0]        wb_rd,
  output logic [XLEN-1:0]   wb_data,
  output logic              mem_valid,
  output logic              mem_we,
  output logic [XLEN-1:0]   mem_addr,
  output logic [STRB_W-1:0] mem_wstrb,
  output logic [XLEN-1:0]   mem_wdata,
  output logic              redirect_valid,
  output logic [XLEN-1:0]   redirect_pc
);

  logic            issue_fire;
  logic [XLEN-1:0] alu_result;
  logic            alu_less;
  logic            alu_zero;
  logic            br_redirect;
  logic [XLEN-1:0] br_target;
  logic [XLEN-1:0] br_link;
  logic            mul_done;
  logic [XLEN-1:0] mul_result;
  logic            div_busy;
  logic            div_done;
  logic [XLEN-1:0] div_result;

  ex_mem_req_if mem_req ();

  assign issue_fire = issue_valid & issue_ready;

  ex_alu u_alu (
    .alu_op (alu_op),
    .src1   (src1),
    .src2   (src2),
    .result (alu_result),
    .less   (alu_less),
    .zero   (alu_zero)
  );

  ex_agu u_agu (
    .issue      (issue_fire),
    .cls        (cls),
    .size       (mem_size),
    .base       (src1),
    .offset     (imm),
    .store_data (store_data),
    .req        (mem_req.source)
  );

  ex_mul u_mul (
    .clk         (clk),
    .arst_n      (arst_n),
    .start       (issue_fire & (cls == CLS_MUL)),
    .is_unsigned (md_unsigned),
    .use_high    (md_high_mod),
    .a           (src1),
    .b           (src2),
    .done        (mul_done),
    .result      (mul_result)
  );

  ex_div u_div (
    .clk         (clk),
    .arst_n      (arst_n),
    .start       (issue_fire & (cls == CLS_DIV)),
    .is_unsigned (md_unsigned),
    .use_mod     (md_high_mod),
    .dividend    (src1),
    .divisor     (src2),
    .busy        (div_busy),
    .done        (div_done),
    .result      (div_result)
  );

  // src1 doubles as rj for jirl style jumps
  ex_branch u_branch (
    .cls         (cls),
    .cond        (br_cond),
    .less        (alu_less),
    .zero        (alu_zero),
    .use_rj      (use_rj),
    .pc          (pc),
    .rj_value    (src1),
    .imm         (imm),
    .pre_taken   (pre_taken),
    .taken       (),
    .redirect    (br_redirect),
    .redirect_pc (br_target),
    .link        (br_link)
  );

  ex_commit u_commit (
    .clk            (clk),
    .arst_n         (arst_n),
    .issue_fire     (issue_fire),
    .cls            (cls),
    .rd             (rd),
    .alu_result     (alu_result),
    .link           (br_link),
    .redirect       (br_redirect),
    .redirect_pc_in (br_target),
    .mem_in         (mem_req.sink),
    .mul_done       (mul_done),
    .mul_result     (mul_result),
    .div_busy       (div_busy),
    .div_done       (div_done),
    .div_result     (div_result),
    .issue_ready    (issue_ready),
    .wb_valid       (wb_valid),
    .wb_rd          (wb_rd),
    .wb_data        (wb_data),
    .mem_valid      (mem_valid),
    .mem_we         (mem_we),
    .mem_addr       (mem_addr),
    .mem_wstrb      (mem_wstrb),
    .mem_wdata      (mem_wdata),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

endmodule

`default_nettype wire

// File: project.f
hdl/ex_pkg.sv
hdl/ex_mem_req_if.sv
hdl/ex_alu.sv
hdl/ex_agu.sv
hdl/ex_mul.sv
hdl/ex_div.sv
hdl/ex_branch.sv
hdl/ex_commit.sv
hdl/ex_stage.sv
verif/ex_stage_assertions.sv
verif/ex_stage_tb.sv

// File: verif/ex_stage_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_assertions (
  input logic clk,
  input logic arst_n,
  input logic issue_valid,
  input logic issue_ready,
  input logic wb_valid,
  input logic mem_valid,
  input logic redirect_valid
);

  logic issue_fire;

  assign issue_fire = issue_valid & issue_ready;

  // no issue into a stalled stage
  a_issue_ready: assert property (@(posedge clk) disable iff (!arst_n)
    issue_valid |-> issue_ready)
    else $error("issue_valid high while issue_ready low");

  a_reset_quiet: assert property (@(posedge clk)
    !arst_n |-> !wb_valid && !mem_valid && !redirect_valid)
    else $error("valid output high during reset");

  // each single-cycle op gives one pulse only
  a_mem_once: assert property (@(posedge clk) disable iff (!arst_n)
    mem_valid |-> $past(issue_fire))
    else $error("mem_valid without an issue in the cycle before");

  a_redirect_once: assert property (@(posedge clk) disable iff (!arst_n)
    redirect_valid |-> $past(issue_fire))
    else $error("redirect_valid without an issue in the cycle before");

  a_wb_once: assert property (@(posedge clk) disable iff (!arst_n)
    wb_valid && $past(wb_valid) |-> $past(issue_fire))
    else $error("wb_valid held for one operation");

endmodule

bind ex_stage ex_stage_assertions u_assertions (
  .clk            (clk),
  .arst_n         (arst_n),
  .issue_valid    (issue_valid),
  .issue_ready    (issue_ready),
  .wb_valid       (wb_valid),
  .mem_valid      (mem_valid),
  .redirect_valid (redirect_valid)
);

`default_nettype wire

// File: verif/ex_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb import ex_pkg::*; ();

  localparam int NUM_TESTS   = 6;
  localparam int NUM_DIVS    = 12;
  localparam int CYCLE_LIMIT = NUM_TESTS * 200 + NUM_DIVS * 40;

  logic              clk;
  logic              arst_n;
  logic              issue_valid;
  logic              issue_ready;
  ex_class_t         cls;
  alu_op_t           alu_op;
  logic              md_unsigned;
  logic              md_high_mod;
  mem_size_t         mem_size;
  br_cond_t          br_cond;
  logic              use_rj;
  logic [XLEN-1:0]   src1;
  logic [XLEN-1:0]   src2;
  logic [XLEN-1:0]   imm;
  logic [XLEN-1:0]   store_data;
  logic [XLEN-1:0]   pc;
  logic [4:0]        rd;
  logic              pre_taken;
  logic              wb_valid;
  logic [4:0]        wb_rd;
  logic [XLEN-1:0]   wb_data;
  logic              mem_valid;
  logic              mem_we;
  logic [XLEN-1:0]   mem_addr;
  logic [STRB_W-1:0] mem_wstrb;
  logic [XLEN-1:0]   mem_wdata;
  logic              redirect_valid;
  logic [XLEN-1:0]   redirect_pc;

  integer          seed;
  int              cycle_cnt = 0;
  int              data_errs = 0;
  int              bit_errs = 0;
  int              strb_errs = 0;
  int              other_errs = 0;
  logic            pend_wb;     // alu result still owed by the DUT
  logic [XLEN-1:0] pend_data;
  logic [4:0]      pend_rd;

  always #10 clk = ~clk;

  ex_stage dut0 (
    .clk            (clk),
    .arst_n         (arst_n),
    .issue_valid    (issue_valid),
    .issue_ready    (issue_ready),
    .cls            (cls),
    .alu_op         (alu_op),
    .md_unsigned    (md_unsigned),
    .md_high_mod    (md_high_mod),
    .mem_size       (mem_size),
    .br_cond        (br_cond),
    .use_rj         (use_rj),
    .src1           (src1),
    .src2           (src2),
    .imm            (imm),
    .store_data     (store_data),
    .pc             (pc),
    .rd             (rd),
    .pre_taken      (pre_taken),
    .wb_valid       (wb_valid),
    .wb_rd          (wb_rd),
    .wb_data        (wb_data),
    .mem_valid      (mem_valid),
    .mem_we         (mem_we),
    .mem_addr       (mem_addr),
    .mem_wstrb      (mem_wstrb),
    .mem_wdata      (mem_wdata),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: run stopped after %0d cycles", cycle_cnt);
      $display("TEST FAIL");
      $finish;
    end
  end

  task automatic check_data(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      data_errs++;
      $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      bit_errs++;
      $display("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_strobe(input string name, input logic [STRB_W-1:0] got,
                              input logic [STRB_W-1:0] exp);
    if (got !== exp) begin
      strb_errs++;
      $display("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic ref_alu(input alu_op_t op, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, output logic [XLEN-1:0] r);
    r = '0;
    case (1'b1)
      op[ALU_ADD]:  r = a + b;
      op[ALU_SUB]:  r = a - b;
      op[ALU_SLT]:  r = ($signed(a) < $signed(b)) ? 1 : 0;
      op[ALU_SLTU]: r = (a < b) ? 1 : 0;
      op[ALU_AND]:  r = a & b;
      op[ALU_NOR]:  r = ~(a | b);
      op[ALU_OR]:   r = a | b;
      op[ALU_XOR]:  r = a ^ b;
      op[ALU_SLL]:  r = a << b[4:0];
      op[ALU_SRL]:  r = a >> b[4:0];
      op[ALU_SRA]:  r = $signed(a) >>> b[4:0];
      op[ALU_LUI]:  r = b;
      default:      r = '0;
    endcase
  endtask

  task automatic ref_mul(input logic uns, input logic high, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, output logic [XLEN-1:0] r);
    logic [2*XLEN-1:0] ext_a;
    logic [2*XLEN-1:0] ext_b;
    logic [2*XLEN-1:0] prod;
    ext_a = uns ? {{XLEN{1'b0}}, a} : {{XLEN{a[XLEN-1]}}, a};
    ext_b = uns ? {{XLEN{1'b0}}, b} : {{XLEN{b[XLEN-1]}}, b};
    prod  = ext_a * ext_b;  // low 64 bits are right for both signednesses
    r = high ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
  endtask

  task automatic ref_div(input logic uns, input logic get_mod, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, output logic [XLEN-1:0] r);
    logic signed [XLEN-1:0] sa;
    logic signed [XLEN-1:0] sb;
    logic [XLEN-1:0]        q;
    logic [XLEN-1:0]        m;
    sa = a;
    sb = b;
    if (b == '0) begin
      q = '1;
      m = a;
    end else if (!uns && a == 32'h8000_0000 && b == '1) begin
      q = a;
      m = '0;
    end else if (uns) begin
      q = a / b;
      m = a % b;
    end else begin
      q = sa / sb;  // truncates toward zero
      m = sa % sb;
    end
    r = get_mod ? m : q;
  endtask

  task automatic ref_branch(input br_cond_t cond, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b, output logic taken);
    case (cond)
      BR_EQ:   taken = (a == b);
      BR_NE:   taken = (a != b);
      BR_LT:   taken = ($signed(a) < $signed(b));
      BR_GE:   taken = ($signed(a) >= $signed(b));
      BR_LTU:  taken = (a < b);
      BR_GEU:  taken = (a >= b);
      default: taken = 1'b1;
    endcase
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic idle_inputs();  // rd keeps counting across tests
    issue_valid = 1'b0;
    cls         = CLS_ALU;
    alu_op      = alu_op_t'(1 << ALU_ADD);
    md_unsigned = 1'b0;
    md_high_mod = 1'b0;
    mem_size    = SIZE_WORD;
    br_cond     = BR_EQ;
    use_rj      = 1'b0;
    src1        = '0;
    src2        = '0;
    imm         = '0;
    store_data  = '0;
    pc          = '0;
    pre_taken   = 1'b0;
  endtask

  task automatic check_wb_pending();
    check_bit("wb_valid", wb_valid, pend_wb);
    if (pend_wb) begin
      check_data("wb_data", wb_data, pend_data);
      check_data("wb_rd", wb_rd, pend_rd);
    end
  endtask

  // issue one alu op and check the previous one in the same cycle
  task automatic alu_issue(input alu_op_t op, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b);
    next_cycle();
    check_wb_pending();
    issue_valid = 1'b1;
    cls         = CLS_ALU;
    alu_op      = op;
    src1        = a;
    src2        = b;
    rd          = rd + 5'd1;
    ref_alu(op, a, b, pend_data);
    pend_rd = rd;
    pend_wb = 1'b1;
  endtask

  task automatic test_alu();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    for (int op = 0; op < 12; op++) begin
      for (int v = 0; v < 6; v++) begin
        a = $random(seed);
        b = $random(seed);
        case (v)
          2: begin
            a = 32'h8000_0000;
            b = 32'h0000_0001;
          end
          3: begin  // shift by 0
            a = 32'h0000_0001;
            b = 32'h8000_0000;
          end
          4: begin  // shift by 31
            a = 32'hffff_ffff;
            b = 32'h7fff_ffff;
          end
          5: b = a;
          default: ;
        endcase
        alu_issue(alu_op_t'(1 << op), a, b);
      end
    end
    next_cycle();
    check_wb_pending();
    idle_inputs();
    pend_wb = 1'b0;
  endtask

  task automatic test_mul();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] exp;
    for (int mode = 0; mode < 4; mode++) begin
      for (int v = 0; v < 4; v++) begin
        a = $random(seed);
        b = $random(seed);
        case (v)
          1: begin
            a = a | 32'h8000_0000;
            b = b & 32'h7fff_ffff;
          end
          2: begin
            a = a | 32'h8000_0000;
            b = b | 32'h8000_0000;
          end
          3: begin
            a = 32'h8000_0000;
            b = 32'h8000_0000;
          end
          default: ;
        endcase
        ref_mul(mode[0], mode[1], a, b, exp);
        next_cycle();
        issue_valid = 1'b1;
        cls         = CLS_MUL;
        md_unsigned = mode[0];
        md_high_mod = mode[1];
        src1        = a;
        src2        = b;
        rd          = rd + 5'd1;
        next_cycle();
        idle_inputs();
        check_bit("issue_ready", issue_ready, 1'b0);
        check_bit("wb_valid", wb_valid, 1'b0);
        repeat (MUL_LAT - 1) next_cycle();
        check_bit("wb_valid", wb_valid, 1'b1);
        check_data("wb_data", wb_data, exp);
        check_data("wb_rd", wb_rd, rd);
      end
    end
  endtask

  task automatic test_div();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] exp;
    int              n;
    for (int mode = 0; mode < 4; mode++) begin
      for (int v = 0; v < 3; v++) begin
        a = $random(seed);
        b = $random(seed);
        b = $signed(b) >>> 18;  // keeps quotients large
        if (v == 1) b = '0;
        if (v == 2) begin
          a = 32'h8000_0000;
          b = 32'hffff_ffff;
        end
        ref_div(mode[0], mode[1], a, b, exp);
        next_cycle();
        issue_valid = 1'b1;
        cls         = CLS_DIV;
        md_unsigned = mode[0];
        md_high_mod = mode[1];
        src1        = a;
        src2        = b;
        rd          = rd + 5'd1;
        next_cycle();
        idle_inputs();
        n = 1;
        while (!wb_valid && n <= DIV_STEPS + 4) begin
          check_bit("issue_ready", issue_ready, 1'b0);
          next_cycle();
          n++;
        end
        if (!wb_valid) begin
          other_errs++;
          $display("divide of %h by %h never returned a result", a, b);
        end else begin
          if (n != DIV_STEPS + 1) begin
            other_errs++;
            $display("divide result came %0d cycles after issue, not %0d", n, DIV_STEPS + 1);
          end
          check_data("wb_data", wb_data, exp);
          check_data("wb_rd", wb_rd, rd);
        end
      end
    end
  endtask

  task automatic test_mem();
    logic [XLEN-1:0]   base;
    logic [XLEN-1:0]   ofs;
    logic [XLEN-1:0]   data;
    logic [XLEN-1:0]   exp_wdata;
    logic [STRB_W-1:0] exp_strb;
    for (int sz = 0; sz < 3; sz++) begin
      for (int off = 0; off < 4; off++) begin
        for (int st = 0; st < 2; st++) begin
          base      = $random(seed);
          ofs       = $random(seed);
          data      = $random(seed);
          base[1:0] = off[1:0];
          ofs[1:0]  = 2'b00;
          case (sz)
            0: begin
              exp_strb  = 4'b0001 << off;
              exp_wdata = {4{data[7:0]}};
            end
            1: begin
              exp_strb  = 4'b0011 << off;
              exp_wdata = {2{data[15:0]}};
            end
            default: begin
              exp_strb  = 4'b1111 << off;
              exp_wdata = data;
            end
          endcase
          next_cycle();
          issue_valid = 1'b1;
          cls         = st ? CLS_STORE : CLS_LOAD;
          mem_size    = mem_size_t'(sz);
          src1        = base;
          imm         = ofs;
          store_data  = data;
          next_cycle();
          idle_inputs();
          check_bit("mem_valid", mem_valid, 1'b1);
          check_bit("mem_we", mem_we, st[0]);
          check_data("mem_addr", mem_addr, base + ofs);
          check_strobe("mem_wstrb", mem_wstrb, exp_strb);
          if (st) check_data("mem_wdata", mem_wdata, exp_wdata);
          check_bit("wb_valid", wb_valid, 1'b0);
          check_bit("redirect_valid", redirect_valid, 1'b0);
        end
      end
    end
  endtask

  // one branch or jump, checked one cycle later
  task automatic branch_issue(input ex_class_t kind, input br_cond_t cond,
                              input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                              input logic pre, input logic via_rj);
    logic            taken;
    logic [XLEN-1:0] pc_v;
    logic [XLEN-1:0] ofs;
    logic [XLEN-1:0] target;
    pc_v       = $random(seed);
    pc_v[1:0]  = 2'b00;
    ofs        = $random(seed);
    ofs        = $signed(ofs) >>> 14;
    taken      = 1'b1;
    if (kind == CLS_BRANCH) ref_branch(cond, a, b, taken);
    target = (via_rj ? a : pc_v) + (ofs << 2);
    next_cycle();
    issue_valid = 1'b1;
    cls         = kind;
    br_cond     = cond;
    case (cond)
      BR_EQ, BR_NE:   alu_op = alu_op_t'(1 << ALU_SUB);
      BR_LT, BR_GE:   alu_op = alu_op_t'(1 << ALU_SLT);
      BR_LTU, BR_GEU: alu_op = alu_op_t'(1 << ALU_SLTU);
      default:        alu_op = alu_op_t'(1 << ALU_ADD);
    endcase
    src1      = a;
    src2      = b;
    imm       = ofs;
    pc        = pc_v;
    pre_taken = pre;
    use_rj    = via_rj;
    rd        = rd + 5'd1;
    next_cycle();
    idle_inputs();
    check_bit("redirect_valid", redirect_valid, taken != pre);
    if (taken != pre) check_data("redirect_pc", redirect_pc, taken ? target : pc_v + 4);
    check_bit("wb_valid", wb_valid, kind == CLS_JUMP);
    if (kind == CLS_JUMP) begin
      check_data("wb_data", wb_data, pc_v + 4);
      check_data("wb_rd", wb_rd, rd);
    end
  endtask

  task automatic test_branch();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    for (int c = 0; c < 7; c++) begin
      for (int rel = 0; rel < 4; rel++) begin
        for (int p = 0; p < 2; p++) begin
          a = $random(seed);
          b = $random(seed);
          case (rel)
            0: b = a;
            1: begin
              a = a & 32'h0fff_ffff;
              b = a + 1;
            end
            2: begin
              a = (a & 32'h0fff_ffff) + 1;
              b = a - 1;
            end
            default: begin  // signs split
              a = a | 32'h8000_0000;
              b = b & 32'h7fff_ffff;
            end
          endcase
          branch_issue(CLS_BRANCH, br_cond_t'(c), a, b, p[0], 1'b0);
        end
      end
    end
  endtask

  task automatic test_jump();
    for (int k = 0; k < 8; k++) begin
      branch_issue(CLS_JUMP, BR_ALWAYS, $random(seed), $random(seed), k[0], k[1]);
    end
  endtask

  initial begin
    seed   = 32'h7c10b437;
    clk    = 1'b0;
    arst_n = 1'b0;
    rd     = 5'd0;
    pend_wb   = 1'b0;
    pend_data = '0;
    pend_rd   = '0;
    idle_inputs();
    repeat (5) @(posedge clk);
    #2;
    arst_n = 1'b1;
    check_bit("issue_ready", issue_ready, 1'b1);
    check_bit("wb_valid", wb_valid, 1'b0);
    check_bit("mem_valid", mem_valid, 1'b0);
    check_bit("redirect_valid", redirect_valid, 1'b0);
    test_alu();
    test_mul();
    test_div();
    test_mem();
    test_branch();
    test_jump();
    next_cycle();
    $display("errors: data %0d, bit %0d, strobe %0d, other %0d",
             data_errs, bit_errs, strb_errs, other_errs);
    if (data_errs + bit_errs + strb_errs + other_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
